/* sim/nco_cases.txt */
# W addr data          apb write, hex
# R addr data err      apb read, hex data, expected pslverr 0 or 1
# F name frames busy   run frames, busy 1 adds a strobe mid frame
F reset_silence 2 0
W 00 000000a3
W 04 00000002
W 08 0001ffff
R 00 000000a3 0
R 04 00000002 0
R 08 0000ffff 0
W 0c 00000055
R 0c 00000000 1
W 40 00000011
W 48 00000000
R 40 00000000 1
R 00 000000a3 0
R 08 0000ffff 0
F square_oct10 4 0
W 00 000000c3
F square_oct12 4 0
W 10 0000003a
W 14 00000001
W 18 00008000
W 20 00000074
W 24 00000003
W 28 00004000
W 30 000000b1
W 34 00000000
W 38 00001234
R 10 0000003a 0
R 14 00000001 0
R 18 00008000 0
R 20 00000074 0
R 24 00000003 0
R 28 00004000 0
R 30 000000b1 0
R 34 00000000 0
R 38 00001234 0
F four_voice_mix 6 0
F busy_strobe 3 1
F after_busy 2 0

/* list.f */
source/nco_pkg.sv
source/voice_regs.sv
source/nco_sequencer.sv
source/pitch_table.sv
source/phase_accum_bank.sv
source/wave_level.sv
source/voice_mixer.sv
source/nco_multi_top.sv
sim/tb_nco_multi.sv

/* run_sim.sh */
#!/bin/sh

obj=obj_dir
log=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_nco_multi \
  -f list.f --Mdir "$obj" -o tb_nco_multi
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./"$obj"/tb_nco_multi > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1

/* sim/tb_nco_multi.sv */
`timescale 1ns/100ps

module tb_nco_multi;
  import nco_pkg::*;

  localparam int num_voices  = 4;
  localparam int mix_width   = sample_width + $clog2(num_voices);
  localparam int frame_edges = 17;    // accepting edge to sample_valid
  localparam int wait_limit  = 100;   // cycles before a wait gives up

  logic                        clk50mhz;
  logic                        rst_n;
  apb_req_t                    apb_req;
  apb_rsp_t                    apb_rsp;
  logic                        sample_strobe;
  logic signed [mix_width-1:0] mix_out;
  logic                        sample_valid;

  ////////////////////
  // reference model state, mirrors the register bank
  logic [3:0]  m_note  [num_voices];
  logic [3:0]  m_oct   [num_voices];
  logic [1:0]  m_wave  [num_voices];
  logic [15:0] m_level [num_voices];
  logic [31:0] m_acc   [num_voices];   // model phase accumulators

  logic [31:0] rng_state;
  int          checks;
  int          errors;
  int          timeouts;
  bit          abort;   // set on a timeout, stops the case file

  nco_multi_top #(.num_voices(num_voices)) UUT (
    .clk50mhz(clk50mhz), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .sample_strobe(sample_strobe), .mix_out(mix_out), .sample_valid(sample_valid)
  );

  initial begin
    clk50mhz = 1'b0;
    forever #10 clk50mhz = ~clk50mhz;   // 50 MHz
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // lowest octave base moved up by the octave, notes 12..15 silent
  function automatic logic [31:0] model_increment(input logic [3:0] note, input logic [3:0] oct);
    logic [31:0] base;
    base = 32'd0;
    if (note < 4'd12) base = {8'd0, note_base[note]};
    return base << oct;   // top bits are lost
  endfunction

  function automatic int model_wave(input logic [1:0] wave, input logic [31:0] ph);
    logic [15:0] bits;
    bits = 16'd0;
    case (wave)
      wave_saw:    bits = ph[31:16] ^ 16'h8000;
      wave_square: return ph[31] ? -32767 : 32767;
      wave_tri: begin
        bits = ph[31] ? ~ph[30:15] : ph[30:15];   // fold the second half
        bits = bits ^ 16'h8000;
      end
      default:     return 0;
    endcase
    return int'($signed(bits));
  endfunction

  // one frame: every voice advances once, scaled samples are summed
  function automatic int model_frame();
    int     sum;
    longint prod;
    sum = 0;
    for (int v = 0; v < num_voices; v++) begin
      m_acc[v] = m_acc[v] + model_increment(m_note[v], m_oct[v]);
      prod     = longint'(model_wave(m_wave[v], m_acc[v])) * longint'(m_level[v]);
      sum      = sum + int'(prod >>> 16);
    end
    return sum;
  endfunction

  function automatic bit addr_mapped(input logic [7:0] addr);
    return (addr[7:4] < num_voices) &&
           (addr[3:0] == 4'h0 || addr[3:0] == 4'h4 || addr[3:0] == 4'h8);
  endfunction

  task automatic check_value(input string name, input longint exp, input longint act);
    checks++;
    assert (exp == act) else begin
      errors++;
      $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  ////////////////////
  // APB master, zero wait slave but pready is still honoured
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int n;
    @(negedge clk50mhz);
    apb_req.psel   = 1'b1;   // setup phase
    apb_req.pwrite = wr;
    apb_req.paddr  = addr;
    apb_req.pwdata = wdata;
    @(negedge clk50mhz);
    apb_req.penable = 1'b1;  // access phase
    n = 0;
    while (!apb_rsp.pready && n < wait_limit) begin
      @(negedge clk50mhz);
      n++;
    end
    if (!apb_rsp.pready) begin
      timeouts++;
      abort = 1'b1;
      $display("timeout: pready stayed low for address 0x%02h", addr);
    end
    @(posedge clk50mhz);
    rdata = apb_rsp.prdata;   // pre-edge values
    err   = apb_rsp.pslverr;
    @(negedge clk50mhz);
    apb_req = '0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    int          v;
    apb_access(1'b1, addr, data, rd, err);
    check_value($sformatf("write_%02h pslverr", addr), !addr_mapped(addr), err);
    if (addr_mapped(addr)) begin
      v = int'(addr[7:4]);
      case (addr[3:0])
        4'h0: begin
          m_note[v] = data[3:0];
          m_oct[v]  = data[7:4];
        end
        4'h4:    m_wave[v]  = data[1:0];
        default: m_level[v] = data[15:0];
      endcase
    end
  endtask

  task automatic read_reg(input logic [7:0] addr, input logic [31:0] exp_data, input bit exp_err);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b0, addr, 32'd0, rd, err);
    check_value($sformatf("read_%02h prdata", addr), exp_data, rd);
    check_value($sformatf("read_%02h pslverr", addr), exp_err, err);
  endtask

  ////////////////////
  // frame runs with random idle gaps
  task automatic run_frames(input string name, input int count, input bit busy_strobe);
    int edges;
    int gap;
    int extra;
    int expected;
    for (int f = 0; f < count && !abort; f++) begin
      rng_state = xorshift(rng_state);
      gap = int'(rng_state % 8);
      repeat (gap) @(negedge clk50mhz);
      @(negedge clk50mhz);
      sample_strobe = 1'b1;
      @(negedge clk50mhz);
      sample_strobe = 1'b0;   // accepted at the edge just passed
      edges = 0;
      while (!sample_valid && edges < wait_limit) begin
        @(negedge clk50mhz);
        edges++;
        sample_strobe = busy_strobe && (edges == 5);   // lands mid frame
      end
      sample_strobe = 1'b0;
      if (!sample_valid) begin
        timeouts++;
        abort = 1'b1;
        $display("timeout: no sample_valid within %0d cycles in case %s", wait_limit, name);
      end else begin
        expected = model_frame();
        check_value($sformatf("%s frame %0d mix_out", name, f), expected, mix_out);
        check_value($sformatf("%s frame %0d latency", name, f), frame_edges, edges);
        @(negedge clk50mhz);
        check_value($sformatf("%s frame %0d pulse end", name, f), 0, sample_valid);
        if (busy_strobe) begin
          extra = 0;
          for (int i = 0; i < 2 * frame_edges; i++) begin
            @(negedge clk50mhz);
            if (sample_valid) extra++;
          end
          check_value($sformatf("%s frame %0d extra pulses", name, f), 0, extra);
        end
      end
    end
  endtask

  initial begin
    string       line;
    string       case_name;
    int          fd;
    int          n;
    int          count;
    int          flag;
    logic [7:0]  addr;
    logic [31:0] data;
    apb_req       = '0;
    sample_strobe = 1'b0;
    rst_n         = 1'b0;
    rng_state     = 32'hd4cd;
    checks        = 0;
    errors        = 0;
    timeouts      = 0;
    abort         = 1'b0;
    for (int v = 0; v < num_voices; v++) begin
      m_note[v]  = '0;
      m_oct[v]   = '0;
      m_wave[v]  = '0;
      m_level[v] = '0;
      m_acc[v]   = '0;
    end
    repeat (4) @(negedge clk50mhz);
    rst_n = 1'b1;

    // no strobe, no sample
    for (int i = 0; i < 2 * frame_edges; i++) begin
      @(negedge clk50mhz);
      check_value("idle_no_strobe sample_valid", 0, sample_valid);
    end
    check_value("idle_no_strobe mix_out", 0, mix_out);

    fd = $fopen("sim/nco_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the case file sim/nco_cases.txt");
    end else begin
      while (!abort && $fgets(line, fd) > 0) begin
        if (line.len() > 0) begin
          case (line.getc(0))
            "W": begin
              n = $sscanf(line, "W %h %h", addr, data);
              if (n == 2) begin
                write_reg(addr, data);
              end else begin
                errors++;
                $display("could not parse case line: %s", line);
              end
            end
            "R": begin
              n = $sscanf(line, "R %h %h %d", addr, data, flag);
              if (n == 3) begin
                read_reg(addr, data, flag[0]);
              end else begin
                errors++;
                $display("could not parse case line: %s", line);
              end
            end
            "F": begin
              n = $sscanf(line, "F %s %d %d", case_name, count, flag);
              if (n == 3) begin
                run_frames(case_name, count, flag[0]);
              end else begin
                errors++;
                $display("could not parse case line: %s", line);
              end
            end
            default: ;   // comment or blank
          endcase
        end
      end
      $fclose(fd);
    end

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0 && checks > 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* source/nco_multi_top.sv */
`timescale 1ns/100ps

module nco_multi_top #(
  parameter  int num_voices = 4,
  localparam int mix_width  = nco_pkg::sample_width + $clog2(num_voices)
) (
  input  logic                        clk50mhz,
  input  logic                        rst_n,
  input  nco_pkg::apb_req_t           apb_req,
  output nco_pkg::apb_rsp_t           apb_rsp,
  input  logic                        sample_strobe,
  output logic signed [mix_width-1:0] mix_out,
  output logic                        sample_valid
);
  import nco_pkg::*;

  localparam int sel_width = $clog2(num_voices);

  voice_cfg_t [num_voices-1:0]    cfg_all;
  voice_cfg_t                     cur_cfg;     // voice now in the pipeline
  logic [sel_width-1:0]           voice_sel;
  logic                           load_en;
  logic                           step_en;
  logic                           shape_en;
  logic                           store_en;
  logic                           frame_done;
  logic [acc_width-1:0]           increment;
  logic [acc_width-1:0]           phase;
  logic signed [sample_width-1:0] sample;

  assign cur_cfg = cfg_all[voice_sel];

  ////////////////////
  // register bank and control
  voice_regs #(.num_voices(num_voices)) u_regs (
    .clk50mhz(clk50mhz), .rst_n(rst_n),
    .apb_req(apb_req), .apb_rsp(apb_rsp), .cfg_all(cfg_all)
  );

  nco_sequencer #(.num_voices(num_voices)) u_seq (
    .clk50mhz(clk50mhz), .rst_n(rst_n), .sample_strobe(sample_strobe),
    .voice_sel(voice_sel), .load_en(load_en), .step_en(step_en),
    .shape_en(shape_en), .store_en(store_en), .frame_done(frame_done)
  );

  ////////////////////
  // shared datapath
  pitch_table u_pitch (
    .clk50mhz(clk50mhz), .rst_n(rst_n), .load_en(load_en),
    .cfg(cur_cfg), .increment(increment)
  );

  phase_accum_bank #(.num_voices(num_voices)) u_accum (
    .clk50mhz(clk50mhz), .rst_n(rst_n), .step_en(step_en),
    .voice_sel(voice_sel), .increment(increment), .phase(phase)
  );

  wave_level u_wave (
    .clk50mhz(clk50mhz), .rst_n(rst_n), .shape_en(shape_en), .phase(phase),
    .wave(cur_cfg.wave), .level(cur_cfg.level), .sample(sample)
  );

  voice_mixer #(.num_voices(num_voices)) u_mix (
    .clk50mhz(clk50mhz), .rst_n(rst_n), .store_en(store_en),
    .frame_done(frame_done), .voice_sel(voice_sel), .sample(sample),
    .mix_out(mix_out), .sample_valid(sample_valid)
  );

endmodule

/* source/voice_mixer.sv */
`timescale 1ns/100ps

module voice_mixer #(
  parameter  int num_voices = 4,
  localparam int mix_width  = nco_pkg::sample_width + $clog2(num_voices)
) (
  input  logic                                    clk50mhz,
  input  logic                                    rst_n,
  input  logic                                    store_en,
  input  logic                                    frame_done,
  input  logic [$clog2(num_voices)-1:0]           voice_sel,
  input  logic signed [nco_pkg::sample_width-1:0] sample,
  output logic signed [mix_width-1:0]             mix_out,
  output logic                                    sample_valid
);
  import nco_pkg::*;

  logic signed [sample_width-1:0] slot [num_voices];   // one sample per voice
  logic signed [mix_width-1:0]    mix_sum;

  // one slot written in each store cycle
  always_ff @(posedge clk50mhz) begin
    if (!rst_n) begin
      for (int i = 0; i < num_voices; i++) begin
        slot[i] <= '0;
      end
    end else if (store_en) begin
      slot[voice_sel] <= sample;
    end
  end

  always_comb begin
    mix_sum = '0;
    for (int i = 0; i < num_voices; i++) begin
      mix_sum = mix_sum + slot[i];   // sign extended
    end
  end

  always_ff @(posedge clk50mhz) begin
    if (!rst_n) begin
      mix_out      <= '0;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= frame_done;           // one pulse per frame
      if (frame_done) mix_out <= mix_sum;   // holds until the next frame
    end
  end

endmodule

/* source/wave_level.sv */
`timescale 1ns/100ps

module wave_level (
  input  logic                                    clk50mhz,
  input  logic                                    rst_n,
  input  logic                                    shape_en,
  input  logic [nco_pkg::acc_width-1:0]           phase,
  input  nco_pkg::wave_t                          wave,
  input  logic [nco_pkg::level_width-1:0]         level,
  output logic signed [nco_pkg::sample_width-1:0] sample
);
  import nco_pkg::*;

  localparam int msb = acc_width - 1;

  logic                           ph_msb;
  logic [sample_width-1:0]        tri_fold;   // folded ramp for the triangle
  logic signed [sample_width-1:0] wave_val;
  logic signed [sample_width+level_width:0] prod;

  assign ph_msb   = phase[msb];
  assign tri_fold = ph_msb ? ~phase[msb-1:msb-16] : phase[msb-1:msb-16];

  ////////////////////
  // waveform from the top phase bits
  always_comb begin
    case (wave)
      wave_saw:    wave_val = {~ph_msb, phase[msb-1:msb-15]};
      wave_square: wave_val = ph_msb ? -16'sd32767 : 16'sd32767;
      wave_tri:    wave_val = {~tri_fold[15], tri_fold[14:0]};
      default:     wave_val = '0;   // silence
    endcase
  end

  // shared multiplier, level is unsigned
  assign prod = wave_val * $signed({1'b0, level});

  always_ff @(posedge clk50mhz) begin
    if (!rst_n) begin
      sample <= '0;
    end else if (shape_en) begin
      sample <= prod[sample_width+level_width-1:level_width];   // >>> 16
    end
  end

endmodule

/* source/phase_accum_bank.sv */
`timescale 1ns/100ps

module phase_accum_bank #(
  parameter int num_voices = 4
) (
  input  logic                          clk50mhz,
  input  logic                          rst_n,
  input  logic                          step_en,
  input  logic [$clog2(num_voices)-1:0] voice_sel,
  input  logic [nco_pkg::acc_width-1:0] increment,
  output logic [nco_pkg::acc_width-1:0] phase
);
  import nco_pkg::*;

  logic [acc_width-1:0] acc [num_voices];   // one accumulator per voice
  logic [acc_width-1:0] next_phase;

  assign next_phase = acc[voice_sel] + increment;   // wraps mod 2^32

  always_ff @(posedge clk50mhz) begin
    if (!rst_n) begin
      for (int i = 0; i < num_voices; i++) begin
        acc[i] <= '0;
      end
      phase <= '0;
    end else if (step_en) begin
      acc[voice_sel] <= next_phase;
      phase          <= next_phase;   // same value, seen in the shape cycle
    end
  end

endmodule

/* source/pitch_table.sv */
`timescale 1ns/100ps

module pitch_table (
  input  logic                          clk50mhz,
  input  logic                          rst_n,
  input  logic                          load_en,
  input  nco_pkg::voice_cfg_t           cfg,
  output logic [nco_pkg::acc_width-1:0] increment
);
  import nco_pkg::*;

  logic [23:0]          base;       // lowest octave increment
  logic [acc_width-1:0] base_ext;
  logic [acc_width-1:0] shifted;

  ////////////////////
  // table lookup, notes past B are silent
  always_comb begin
    base = '0;
    if (cfg.note < 4'd12) begin
      base = note_base[cfg.note];
    end
  end

  // octave up is a left shift, top bits fall off
  assign base_ext = acc_width'(base);
  assign shifted  = base_ext << cfg.octave;

  always_ff @(posedge clk50mhz) begin
    if (!rst_n) begin
      increment <= '0;
    end else if (load_en) begin
      increment <= shifted;   // ready for the step cycle
    end
  end

endmodule

/* source/nco_sequencer.sv */
`timescale 1ns/100ps

module nco_sequencer #(
  parameter int num_voices = 4
) (
  input  logic                          clk50mhz,
  input  logic                          rst_n,
  input  logic                          sample_strobe,
  output logic [$clog2(num_voices)-1:0] voice_sel,
  output logic                          load_en,
  output logic                          step_en,
  output logic                          shape_en,
  output logic                          store_en,
  output logic                          frame_done
);
  import nco_pkg::*;

  localparam int sel_width = $clog2(num_voices);

  seq_state_t           state;
  logic [sel_width-1:0] voice_cnt;   // voice being processed
  logic                 last_voice;

  assign last_voice = (voice_cnt == sel_width'(num_voices - 1));

  ////////////////////
  // frame FSM, four cycles per voice
  always_ff @(posedge clk50mhz) begin
    if (!rst_n) begin
      state      <= st_idle;
      voice_cnt  <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;   // single cycle pulse
      case (state)
        st_idle: begin
          voice_cnt <= '0;
          if (sample_strobe) state <= st_load;   // strobe only taken here
        end
        st_load:  state <= st_step;    // increment lookup
        st_step:  state <= st_shape;   // accumulator advance
        st_shape: state <= st_store;   // wave and level
        st_store: begin
          if (last_voice) begin
            state      <= st_idle;
            voice_cnt  <= '0;
            frame_done <= 1'b1;        // mixer sums on the next edge
          end else begin
            state     <= st_load;
            voice_cnt <= voice_cnt + 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // enables decoded straight from the state
  assign load_en   = (state == st_load);
  assign step_en   = (state == st_step);
  assign shape_en  = (state == st_shape);
  assign store_en  = (state == st_store);
  assign voice_sel = voice_cnt;

endmodule

/* source/voice_regs.sv */
`timescale 1ns/100ps

module voice_regs #(
  parameter int num_voices = 4
) (
  input  logic                                    clk50mhz,
  input  logic                                    rst_n,
  input  nco_pkg::apb_req_t                       apb_req,
  output nco_pkg::apb_rsp_t                       apb_rsp,
  output nco_pkg::voice_cfg_t [num_voices-1:0]    cfg_all
);
  import nco_pkg::*;

  localparam int sel_width = $clog2(num_voices);

  logic [7:0]           voice_idx;   // window number from the address
  logic [7:0]           field_off;   // offset inside the window
  logic [sel_width-1:0] vsel;
  logic                 field_ok;
  logic                 hit;         // mapped register
  logic                 access;      // APB access phase

  ////////////////////
  // address decode
  assign voice_idx = apb_req.paddr / voice_stride;
  assign field_off = apb_req.paddr % voice_stride;
  assign vsel      = sel_width'(voice_idx);
  assign field_ok  = (field_off == addr_note_oct) || (field_off == addr_wave) ||
                     (field_off == addr_level);
  assign hit       = field_ok && (voice_idx < num_voices);
  assign access    = apb_req.psel && apb_req.penable;

  // zero wait states, error only on unmapped access
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access && !hit;

  // read mux
  always_comb begin
    apb_rsp.prdata = '0;
    if (hit) begin
      case (field_off)
        addr_note_oct: apb_rsp.prdata = {24'd0, cfg_all[vsel].octave, cfg_all[vsel].note};
        addr_wave:     apb_rsp.prdata = {30'd0, cfg_all[vsel].wave};
        addr_level:    apb_rsp.prdata = {16'd0, cfg_all[vsel].level};
        default:       apb_rsp.prdata = '0;
      endcase
    end
  end

  ////////////////////
  // field update, takes effect at the access edge
  always_ff @(posedge clk50mhz) begin
    if (!rst_n) begin
      cfg_all <= '0;   // all voices silent
    end else if (access && apb_req.pwrite && hit) begin
      case (field_off)
        addr_note_oct: begin
          cfg_all[vsel].note   <= apb_req.pwdata[3:0];
          cfg_all[vsel].octave <= apb_req.pwdata[7:4];
        end
        addr_wave:  cfg_all[vsel].wave  <= wave_t'(apb_req.pwdata[1:0]);
        addr_level: cfg_all[vsel].level <= apb_req.pwdata[level_width-1:0];
        default: ;
      endcase
    end
  end

endmodule

/* source/nco_pkg.sv */
package nco_pkg;

  ////////////////////
  // datapath widths
  localparam int acc_width    = 32;   // phase accumulator
  localparam int sample_width = 16;   // signed voice sample
  localparam int level_width  = 16;   // unsigned voice level

  // waveform opcode, value 0 is silence
  typedef enum logic [1:0] {
    wave_off    = 2'd0,
    wave_saw    = 2'd1,
    wave_square = 2'd2,
    wave_tri    = 2'd3
  } wave_t;

  // per-voice configuration, 26 bits
  typedef struct packed {
    logic [3:0]             note;     // 0..11, 12..15 give no pitch
    logic [3:0]             octave;   // left shift of the base increment
    wave_t                  wave;
    logic [level_width-1:0] level;
  } voice_cfg_t;

  ////////////////////
  // APB request and response
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // frame sequencer states
  typedef enum logic [2:0] {
    st_idle  = 3'd0,
    st_load  = 3'd1,
    st_step  = 3'd2,
    st_shape = 3'd3,
    st_store = 3'd4
  } seq_state_t;

  ////////////////////
  // lowest octave increments, C up to B, for a 48 kHz frame rate
  localparam logic [23:0] note_base [12] = '{
    24'd1463107, 24'd1550108, 24'd1642280, 24'd1739936,
    24'd1843398, 24'd1953015, 24'd2069148, 24'd2192180,
    24'd2322531, 24'd2460658, 24'd2606975, 24'd2761997
  };

  // register map, offsets inside one voice window
  localparam logic [7:0] addr_note_oct = 8'h00;   // note 3..0, octave 7..4
  localparam logic [7:0] addr_wave     = 8'h04;
  localparam logic [7:0] addr_level    = 8'h08;
  localparam logic [7:0] voice_stride  = 8'h10;   // window size per voice

endpackage
